//--- list.f
hw/soc_pkg.sv
hw/periph_bus_if.sv
hw/addr_decoder.sv
hw/data_sram.sv
hw/periph_regs.sv
hw/resp_builder.sv
hw/soc_fabric_top.sv
bench/soc_fabric_assertions.sv
bench/tb_soc_fabric.sv

//--- Bender.yml
package:
  name: soc_fabric

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/periph_bus_if.sv
      - hw/addr_decoder.sv
      - hw/data_sram.sv
      - hw/periph_regs.sv
      - hw/resp_builder.sv
      - hw/soc_fabric_top.sv
  - target: test
    files:
      - bench/soc_fabric_assertions.sv
      - bench/tb_soc_fabric.sv

//--- bench/tb_soc_fabric.sv
`timescale 1ns/1ns

module tb_soc_fabric
  import soc_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_SRAM_OPS = 200;
  localparam int NUM_TXN      = SRAM_WORDS + 3 * NUM_SRAM_OPS + 200;

  logic                  core_clk;
  logic                  reset_n;
  logic [ADDR_W-1:0]     awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_W-1:0]     wdata;
  logic [STRB_W-1:0]     wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [ADDR_W-1:0]     araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_W-1:0]     rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic [GPIO_IN_W-1:0]  gpio_in;
  logic [GPIO_OUT_W-1:0] gpio_out;
  logic                  irq;
  logic [IRQ_ID_W-1:0]   irq_id;

  int                 seed = 32'hb377_9911;
  logic [DATA_W-1:0]  sram_model [SRAM_WORDS];
  logic [IRQ_NUM-1:0] model_en;
  logic [IRQ_NUM-1:0] model_pend;

  soc_fabric_top i_soc_fabric_top (
    .core_clk         (core_clk),
    .reset_n          (reset_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready),
    .gpio_i           (gpio_in),
    .gpio_o           (gpio_out),
    .irq_o            (irq),
    .irq_id_o         (irq_id)
  );

  initial begin
    core_clk = 1'b0;
    forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
  end

  task automatic fail_now(input string reason);
    $display("Failure at %0t ns: %s", $time, reason);
    $display("Simulation FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  initial begin
    #((NUM_TXN * 40 + RESET_CYCLES) * CLK_PERIOD);
    fail_now("watchdog expired, a transaction never completed");
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [ADDR_W-1:0] sram_addr(input int idx);
    return SRAM_BASE + ADDR_W'(idx * 4);
  endfunction

  // Odd multiplier so every index bit matters
  function automatic logic [DATA_W-1:0] fill_word(input int idx);
    return (DATA_W'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] expected_id(input logic [IRQ_NUM-1:0] act);
    for (int i = IRQ_NUM - 1; i >= 0; i--) begin
      if (act[i]) return i;
    end
    return 0;
  endfunction

  task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
    @(posedge core_clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge core_clk); while (!awready);
    check_value("s_axil_wready_o", 1, wready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic collect_write(input int stall, output logic [1:0] resp);
    repeat (stall) @(posedge core_clk);
    bready <= 1'b1;
    do @(posedge core_clk); while (!bvalid);
    bready <= 1'b0;
    resp = bresp;
  endtask

  task automatic collect_read(input int stall, output logic [DATA_W-1:0] data,
                              output logic [1:0] resp);
    repeat (stall) @(posedge core_clk);
    rready <= 1'b1;
    do @(posedge core_clk); while (!rvalid);
    rready <= 1'b0;
    data = rdata;
    resp = rresp;
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int stall,
                           output logic [1:0] resp);
    send_write(addr, data, strb);
    collect_write(stall, resp);
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, input int stall,
                          output logic [DATA_W-1:0] data, output logic [1:0] resp);
    @(posedge core_clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge core_clk); while (!arready);
    arvalid <= 1'b0;
    collect_read(stall, data, resp);
  endtask

  task automatic sram_write(input int idx, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input int stall);
    logic [1:0] resp;
    axi_write(sram_addr(idx), data, strb, stall, resp);
    check_value("s_axil_bresp_o", RESP_OKAY, resp);
    sram_model[idx] = merge_bytes(sram_model[idx], data, strb);
  endtask

  task automatic sram_check(input int idx, input int stall);
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    axi_read(sram_addr(idx), stall, data, resp);
    check_value("s_axil_rresp_o", RESP_OKAY, resp);
    check_value("s_axil_rdata_o", sram_model[idx], data);
  endtask

  task automatic reg_write(input logic [7:0] ofs, input logic [DATA_W-1:0] data);
    logic [1:0] resp;
    axi_write(REGS_BASE + ADDR_W'(ofs), data, '1, rand_below(4), resp);
    check_value("s_axil_bresp_o", RESP_OKAY, resp);
  endtask

  task automatic reg_expect(input logic [7:0] ofs, input logic [DATA_W-1:0] expected,
                            input string name);
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    axi_read(REGS_BASE + ADDR_W'(ofs), rand_below(4), data, resp);
    check_value("s_axil_rresp_o", RESP_OKAY, resp);
    check_value(name, expected, data);
  endtask

  task automatic check_irq();
    check_value("irq_o", 32'(|(model_en & model_pend)), 32'(irq));
    check_value("irq_id_o", expected_id(model_en & model_pend), 32'(irq_id));
    reg_expect(OFS_IRQ_ID, expected_id(model_en & model_pend), "IRQ_ID register");
  endtask

  // Write held on bready while a read waits behind it
  task automatic stalled_write_read(input int idx, input int stall);
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [1:0]        resp;
    logic [1:0]        held;
    data = $random(seed);
    strb = STRB_W'(rand_below(16));
    send_write(sram_addr(idx), data, strb);
    araddr  <= sram_addr(idx);
    arvalid <= 1'b1;
    do @(posedge core_clk); while (!bvalid);
    held = bresp;
    repeat (stall) begin
      @(posedge core_clk);
      check_value("s_axil_bvalid_o", 1, bvalid);
      check_value("s_axil_bresp_o", held, bresp);
      check_value("s_axil_arready_o", 0, arready);
    end
    bready <= 1'b1;
    @(posedge core_clk);
    check_value("s_axil_arready_o", 0, arready);
    bready <= 1'b0;
    check_value("s_axil_bresp_o", RESP_OKAY, held);
    sram_model[idx] = merge_bytes(sram_model[idx], data, strb);
    do @(posedge core_clk); while (!arready);
    arvalid <= 1'b0;
    collect_read(stall, data, resp);
    check_value("s_axil_rresp_o", RESP_OKAY, resp);
    check_value("s_axil_rdata_o", sram_model[idx], data);
  endtask

  initial begin
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic [ADDR_W-1:0] bad;
    int                idx;
    int                polls;
    reset_n    = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    gpio_in    = '0;
    model_en   = '0;
    model_pend = '0;
    repeat (RESET_CYCLES) @(posedge core_clk);
    reset_n <= 1'b1;

    for (int i = 0; i < SRAM_WORDS; i++) begin
      sram_write(i, fill_word(i), '1, 0);  // Known contents
    end

    for (int n = 0; n < NUM_SRAM_OPS; n++) begin
      idx = rand_below(SRAM_WORDS);
      sram_write(idx, $random(seed), STRB_W'(rand_below(16)), rand_below(4));
      sram_check(idx, rand_below(4));
      sram_check(rand_below(SRAM_WORDS), rand_below(4));
    end

    for (int n = 0; n < 4; n++) begin
      data = DATA_W'(rand_below(1 << GPIO_OUT_W));
      reg_write(OFS_GPIO_OUT, data);
      check_value("gpio_o", data, DATA_W'(gpio_out));
      reg_expect(OFS_GPIO_OUT, data, "GPIO_OUT register");
      @(posedge core_clk);
      gpio_in <= gpio_in ^ GPIO_IN_W'(rand_below(15) + 1);
      repeat (3) @(posedge core_clk);
      reg_expect(OFS_GPIO_IN, DATA_W'(gpio_in), "GPIO_IN register");
      model_pend[1] = 1'b1;
    end

    for (int n = 0; n < 8; n++) begin
      idx  = rand_below(SRAM_WORDS);
      data = $random(seed);
      // Low bits alias an SRAM word
      bad = (n == 0) ? 32'h0000_1000 + ADDR_W'(idx * 4) : {1'b1, data[18:0], idx[9:0], 2'b00};
      if (n == 1) bad = REGS_END + 1;
      axi_write(bad, $random(seed), '1, rand_below(4), resp);
      check_value("s_axil_bresp_o", RESP_DECERR, resp);
      axi_read(bad, rand_below(4), data, resp);
      check_value("s_axil_rresp_o", RESP_DECERR, resp);
      check_value("s_axil_rdata_o", 0, data);
      sram_check(idx, 0);
      sram_check(bad[SRAM_IDX_W+1:2], 0);
    end

    reg_write(OFS_IRQ_EN, 3);
    model_en = 2'b11;
    check_irq();
    reg_write(OFS_IRQ_PEND, 3);
    model_pend = '0;
    check_irq();
    reg_write(OFS_TIMER_CMP, 5);
    polls = 0;
    data  = '0;
    while (!data[0]) begin
      if (polls == 20) fail_now("timer interrupt never became pending");
      axi_read(REGS_BASE + ADDR_W'(OFS_IRQ_PEND), 0, data, resp);
      polls++;
    end
    reg_write(OFS_TIMER_CMP, 0);  // Stop further matches
    model_pend = 2'b01;
    reg_expect(OFS_IRQ_PEND, 1, "IRQ_PEND register");
    check_irq();
    @(posedge core_clk);
    gpio_in <= ~gpio_in;
    repeat (5) @(posedge core_clk);
    model_pend = 2'b11;
    check_irq();
    reg_expect(OFS_IRQ_PEND, 3, "IRQ_PEND register");
    reg_write(OFS_IRQ_EN, 1);
    model_en = 2'b01;
    check_irq();
    reg_write(OFS_IRQ_EN, 3);
    model_en = 2'b11;
    reg_write(OFS_IRQ_PEND, 3);
    model_pend = '0;
    check_irq();

    for (int n = 0; n < 20; n++) begin
      stalled_write_read(rand_below(SRAM_WORDS), rand_below(16) + 4);
    end

    repeat (4) @(posedge core_clk);
    if (i_soc_fabric_top.i_soc_fabric_assertions.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_now("bound assertions reported handshake violations");
    end
  end

endmodule

//--- bench/soc_fabric_assertions.sv
`timescale 1ns/1ns

module soc_fabric_assertions
  import soc_pkg::*;
(
  input logic                  core_clk,
  input logic                  reset_n,
  input logic                  s_axil_awvalid_i,
  input logic                  s_axil_wvalid_i,
  input logic                  s_axil_awready_o,
  input logic                  s_axil_wready_o,
  input logic                  s_axil_arready_o,
  input logic                  s_axil_bvalid_o,
  input logic                  s_axil_bready_i,
  input logic [1:0]            s_axil_bresp_o,
  input logic                  s_axil_rvalid_o,
  input logic                  s_axil_rready_i,
  input logic [1:0]            s_axil_rresp_o,
  input logic [DATA_W-1:0]     s_axil_rdata_o,
  input logic                  irq_o,
  input logic [GPIO_OUT_W-1:0] gpio_o
);

  int fail_count = 0;  // Read by the testbench at the end

  property p_b_hold;
    @(posedge core_clk) disable iff (!reset_n)
      s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o);
  endproperty

  property p_r_hold;
    @(posedge core_clk) disable iff (!reset_n)
      s_axil_rvalid_o && !s_axil_rready_i |=>
        s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o);
  endproperty

  // Write taken only with AW and W both presented
  property p_aw_with_w;
    @(posedge core_clk) disable iff (!reset_n)
      s_axil_awready_o |-> s_axil_wready_o && s_axil_awvalid_i && s_axil_wvalid_i;
  endproperty

  // One transaction in flight
  property p_no_accept_pending;
    @(posedge core_clk) disable iff (!reset_n)
      (s_axil_bvalid_o || s_axil_rvalid_o) |->
        !s_axil_awready_o && !s_axil_wready_o && !s_axil_arready_o;
  endproperty

  property p_reset_quiet;
    @(posedge core_clk)
      !reset_n |-> !s_axil_bvalid_o && !s_axil_rvalid_o && !s_axil_awready_o &&
                   !s_axil_wready_o && !s_axil_arready_o && !irq_o && gpio_o == '0;
  endproperty

  a_b_hold: assert property (p_b_hold) else begin
    fail_count++;
    $error("B channel dropped or changed before bready");
  end

  a_r_hold: assert property (p_r_hold) else begin
    fail_count++;
    $error("R channel dropped or changed before rready");
  end

  a_aw_with_w: assert property (p_aw_with_w) else begin
    fail_count++;
    $error("awready high without wready or without both valids");
  end

  a_no_accept_pending: assert property (p_no_accept_pending) else begin
    fail_count++;
    $error("ready raised while a response is pending");
  end

  a_reset_quiet: assert property (p_reset_quiet) else begin
    fail_count++;
    $error("outputs not idle during reset");
  end

endmodule

bind soc_fabric_top soc_fabric_assertions i_soc_fabric_assertions (.*);

//--- hw/soc_fabric_top.sv
`timescale 1ns/1ns

module soc_fabric_top
  import soc_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  reset_n,
  input  logic [ADDR_W-1:0]     s_axil_awaddr_i,
  input  logic                  s_axil_awvalid_i,
  output logic                  s_axil_awready_o,
  input  logic [DATA_W-1:0]     s_axil_wdata_i,
  input  logic [STRB_W-1:0]     s_axil_wstrb_i,
  input  logic                  s_axil_wvalid_i,
  output logic                  s_axil_wready_o,
  output logic [1:0]            s_axil_bresp_o,
  output logic                  s_axil_bvalid_o,
  input  logic                  s_axil_bready_i,
  input  logic [ADDR_W-1:0]     s_axil_araddr_i,
  input  logic                  s_axil_arvalid_i,
  output logic                  s_axil_arready_o,
  output logic [DATA_W-1:0]     s_axil_rdata_o,
  output logic [1:0]            s_axil_rresp_o,
  output logic                  s_axil_rvalid_o,
  input  logic                  s_axil_rready_i,
  input  logic [GPIO_IN_W-1:0]  gpio_i,
  output logic [GPIO_OUT_W-1:0] gpio_o,
  output logic                  irq_o,
  output logic [IRQ_ID_W-1:0]   irq_id_o
);

  logic req_done;
  logic req_write;
  logic req_decerr;
  logic resp_busy;
  logic accept;

  periph_bus_if sram_bus ();
  periph_bus_if regs_bus ();

  // AW and W readies pulse together, so AW stands for a write
  assign accept = s_axil_awready_o | s_axil_arready_o;

  addr_decoder i_addr_decoder (
    .core_clk     (core_clk),
    .reset_n      (reset_n),
    .awvalid_i    (s_axil_awvalid_i),
    .awaddr_i     (s_axil_awaddr_i),
    .wvalid_i     (s_axil_wvalid_i),
    .wdata_i      (s_axil_wdata_i),
    .wstrb_i      (s_axil_wstrb_i),
    .arvalid_i    (s_axil_arvalid_i),
    .araddr_i     (s_axil_araddr_i),
    .awready_o    (s_axil_awready_o),
    .wready_o     (s_axil_wready_o),
    .arready_o    (s_axil_arready_o),
    .resp_busy_i  (resp_busy),
    .sram_bus     (sram_bus.decoder),
    .regs_bus     (regs_bus.decoder),
    .req_done_o   (req_done),
    .req_write_o  (req_write),
    .req_decerr_o (req_decerr)
  );

  data_sram i_data_sram (
    .core_clk (core_clk),
    .bus      (sram_bus.target)
  );

  periph_regs i_periph_regs (
    .core_clk (core_clk),
    .reset_n  (reset_n),
    .bus      (regs_bus.target),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .irq_o    (irq_o),
    .irq_id_o (irq_id_o)
  );

  resp_builder i_resp_builder (
    .core_clk     (core_clk),
    .reset_n      (reset_n),
    .sram_bus     (sram_bus.result),
    .regs_bus     (regs_bus.result),
    .accept_i     (accept),
    .req_done_i   (req_done),
    .req_write_i  (req_write),
    .req_decerr_i (req_decerr),
    .bvalid_o     (s_axil_bvalid_o),
    .bresp_o      (s_axil_bresp_o),
    .bready_i     (s_axil_bready_i),
    .rvalid_o     (s_axil_rvalid_o),
    .rresp_o      (s_axil_rresp_o),
    .rdata_o      (s_axil_rdata_o),
    .rready_i     (s_axil_rready_i),
    .resp_busy_o  (resp_busy)
  );

endmodule

//--- hw/resp_builder.sv
`timescale 1ns/1ns

module resp_builder
  import soc_pkg::*;
(
  input  logic              core_clk,
  input  logic              reset_n,
  periph_bus_if.result      sram_bus,
  periph_bus_if.result      regs_bus,
  input  logic              accept_i,
  input  logic              req_done_i,
  input  logic              req_write_i,
  input  logic              req_decerr_i,
  output logic              bvalid_o,
  output logic [1:0]        bresp_o,
  input  logic              bready_i,
  output logic              rvalid_o,
  output logic [1:0]        rresp_o,
  output logic [DATA_W-1:0] rdata_o,
  input  logic              rready_i,
  output logic              resp_busy_o
);

  logic              busy_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [1:0]        resp_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_sel;
  logic              resp_hs;

  assign resp_hs = (bvalid_q & bready_i) | (rvalid_q & rready_i);

  always_comb begin
    if (req_decerr_i || req_write_i) begin
      rd_sel = '0;  // DECERR reads return zero
    end else if (sram_bus.sel) begin
      rd_sel = sram_bus.rdata;
    end else if (regs_bus.sel) begin
      rd_sel = regs_bus.rdata;
    end else begin
      rd_sel = '0;
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (accept_i) begin
        busy_q <= 1'b1;
      end else if (resp_hs) begin
        busy_q <= 1'b0;
      end
      if (req_done_i && req_write_i) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (req_done_i && !req_write_i) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Held until the handshake
  always_ff @(posedge core_clk) begin
    if (req_done_i) begin
      resp_q  <= req_decerr_i ? RESP_DECERR : RESP_OKAY;
      rdata_q <= rd_sel;
    end
  end

  assign bvalid_o    = bvalid_q;
  assign rvalid_o    = rvalid_q;
  assign bresp_o     = resp_q;
  assign rresp_o     = resp_q;
  assign rdata_o     = rdata_q;
  assign resp_busy_o = busy_q;

endmodule

//--- hw/periph_regs.sv
`timescale 1ns/1ns

module periph_regs
  import soc_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  reset_n,
  periph_bus_if.target          bus,
  input  logic [GPIO_IN_W-1:0]  gpio_i,
  output logic [GPIO_OUT_W-1:0] gpio_o,
  output logic                  irq_o,
  output logic [IRQ_ID_W-1:0]   irq_id_o
);

  logic [7:0]            ofs;
  logic                  wr;
  logic [GPIO_OUT_W-1:0] gpio_out_q;
  logic [GPIO_IN_W-1:0]  gpio_meta_q;
  logic [GPIO_IN_W-1:0]  gpio_sync_q;
  logic [GPIO_IN_W-1:0]  gpio_prev_q;
  logic [DATA_W-1:0]     cmp_q;
  logic [DATA_W-1:0]     cnt_q;
  logic [IRQ_NUM-1:0]    irq_en_q;
  logic [IRQ_NUM-1:0]    irq_pend_q;
  logic [IRQ_NUM-1:0]    irq_set;
  logic [IRQ_NUM-1:0]    irq_clr;
  logic [IRQ_NUM-1:0]    irq_act;
  logic                  timer_hit;

  assign ofs = bus.addr[7:0];
  assign wr  = bus.sel & bus.we;

  assign timer_hit = (cmp_q != '0) && (cnt_q == cmp_q);
  assign irq_set   = {gpio_sync_q != gpio_prev_q, timer_hit};
  assign irq_clr   = (wr && ofs == OFS_IRQ_PEND) ? bus.wdata[IRQ_NUM-1:0] : '0;
  assign irq_act   = irq_pend_q & irq_en_q;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      gpio_out_q  <= '0;
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      gpio_prev_q <= '0;
      cmp_q       <= '0;
      cnt_q       <= '0;
      irq_en_q    <= '0;
      irq_pend_q  <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      gpio_prev_q <= gpio_sync_q;  // Edge detect
      if (timer_hit) begin
        cnt_q <= '0;
      end else if (cmp_q != '0) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // New events win over a clear in the same cycle
      irq_pend_q <= (irq_pend_q & ~irq_clr) | irq_set;
      if (wr) begin
        case (ofs)
          OFS_GPIO_OUT:  gpio_out_q <= bus.wdata[GPIO_OUT_W-1:0];
          OFS_TIMER_CMP: cmp_q      <= bus.wdata;
          OFS_TIMER_CNT: cnt_q      <= bus.wdata;
          OFS_IRQ_EN:    irq_en_q   <= bus.wdata[IRQ_NUM-1:0];
          default: ;
        endcase
      end
    end
  end

  // Highest enabled pending source
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < IRQ_NUM; i++) begin
      if (irq_act[i]) begin
        irq_id_o = i[IRQ_ID_W-1:0];
      end
    end
  end

  assign irq_o  = |irq_act;
  assign gpio_o = gpio_out_q;

  always_comb begin
    case (ofs)
      OFS_GPIO_OUT:  bus.rdata = DATA_W'(gpio_out_q);
      OFS_GPIO_IN:   bus.rdata = DATA_W'(gpio_sync_q);
      OFS_TIMER_CMP: bus.rdata = cmp_q;
      OFS_TIMER_CNT: bus.rdata = cnt_q;
      OFS_IRQ_EN:    bus.rdata = DATA_W'(irq_en_q);
      OFS_IRQ_PEND:  bus.rdata = DATA_W'(irq_pend_q);
      OFS_IRQ_ID:    bus.rdata = DATA_W'(irq_id_o);
      default:       bus.rdata = '0;
    endcase
  end

endmodule

//--- hw/data_sram.sv
`timescale 1ns/1ns

module data_sram
  import soc_pkg::*;
(
  input  logic          core_clk,
  periph_bus_if.target  bus
);

  logic [DATA_W-1:0]     mem [SRAM_WORDS];
  logic [SRAM_IDX_W-1:0] idx;

  // Word index, byte offset dropped
  assign idx = bus.addr[SRAM_IDX_W+1:2];

  always_ff @(posedge core_clk) begin
    if (bus.sel && bus.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  assign bus.rdata = mem[idx];  // Async read in the sel cycle

endmodule

//--- hw/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder
  import soc_pkg::*;
(
  input  logic                 core_clk,
  input  logic                 reset_n,
  input  logic                 awvalid_i,
  input  logic [ADDR_W-1:0]    awaddr_i,
  input  logic                 wvalid_i,
  input  logic [DATA_W-1:0]    wdata_i,
  input  logic [STRB_W-1:0]    wstrb_i,
  input  logic                 arvalid_i,
  input  logic [ADDR_W-1:0]    araddr_i,
  output logic                 awready_o,
  output logic                 wready_o,
  output logic                 arready_o,
  input  logic                 resp_busy_i,
  periph_bus_if.decoder        sram_bus,
  periph_bus_if.decoder        regs_bus,
  output logic                 req_done_o,
  output logic                 req_write_o,
  output logic                 req_decerr_o
);

  logic              wr_go;
  logic              rd_go;
  logic              accept;
  logic [ADDR_W-1:0] req_addr;
  logic              hit_sram;
  logic              hit_regs;
  logic              req_vld_q;
  logic              write_q;
  logic              sram_q;
  logic              regs_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;

  // Write wins when AW and W are both presented
  assign wr_go  = awvalid_i & wvalid_i & ~resp_busy_i;
  assign rd_go  = arvalid_i & ~(awvalid_i & wvalid_i) & ~resp_busy_i;
  assign accept = wr_go | rd_go;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign req_addr = wr_go ? awaddr_i : araddr_i;
  assign hit_sram = (req_addr & SRAM_MASK) == SRAM_BASE;
  assign hit_regs = (req_addr & REGS_MASK) == REGS_BASE;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      req_vld_q <= 1'b0;
      write_q   <= 1'b0;
      sram_q    <= 1'b0;
      regs_q    <= 1'b0;
    end else begin
      req_vld_q <= accept;  // One-cycle execute slot
      if (accept) begin
        write_q <= wr_go;
        sram_q  <= hit_sram;
        regs_q  <= hit_regs;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      addr_q  <= req_addr;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  assign sram_bus.sel   = req_vld_q & sram_q;
  assign sram_bus.we    = write_q;
  assign sram_bus.addr  = addr_q & ~SRAM_MASK;
  assign sram_bus.wdata = wdata_q;
  assign sram_bus.wstrb = wstrb_q;

  assign regs_bus.sel   = req_vld_q & regs_q;
  assign regs_bus.we    = write_q;
  assign regs_bus.addr  = addr_q & ~REGS_MASK;
  assign regs_bus.wdata = wdata_q;
  assign regs_bus.wstrb = wstrb_q;

  assign req_done_o   = req_vld_q;
  assign req_write_o  = write_q;
  assign req_decerr_o = req_vld_q & ~(sram_q | regs_q);  // Unmapped address

endmodule

//--- hw/periph_bus_if.sv
`timescale 1ns/1ns

interface periph_bus_if
  import soc_pkg::*;
();

  logic              sel;
  logic              we;
  logic [ADDR_W-1:0] addr;  // Byte offset inside the target
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic [DATA_W-1:0] rdata;

  modport decoder (output sel, output we, output addr, output wdata, output wstrb);

  modport target (input sel, input we, input addr, input wdata, input wstrb, output rdata);

  // Response side only looks
  modport result (input sel, input rdata);

endinterface

//--- hw/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Address map, inclusive end addresses
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] SRAM_END  = 32'h0000_0FFF;
  localparam logic [ADDR_W-1:0] REGS_BASE = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] REGS_END  = 32'h0001_00FF;

  localparam logic [ADDR_W-1:0] SRAM_MASK = ~(SRAM_END - SRAM_BASE);
  localparam logic [ADDR_W-1:0] REGS_MASK = ~(REGS_END - REGS_BASE);

  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_IDX_W = 10;

  localparam int GPIO_OUT_W = 12;
  localparam int GPIO_IN_W  = 4;

  // Bit 0 timer match, bit 1 GPIO input change
  localparam int IRQ_NUM  = 2;
  localparam int IRQ_ID_W = 5;

  localparam logic [7:0] OFS_GPIO_OUT  = 8'h00;
  localparam logic [7:0] OFS_GPIO_IN   = 8'h04;
  localparam logic [7:0] OFS_TIMER_CMP = 8'h08;
  localparam logic [7:0] OFS_TIMER_CNT = 8'h0C;
  localparam logic [7:0] OFS_IRQ_EN    = 8'h10;
  localparam logic [7:0] OFS_IRQ_PEND  = 8'h14;
  localparam logic [7:0] OFS_IRQ_ID    = 8'h18;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage
